// File: src/array_control.sv
`timescale 1ns/1ns

module array_control import sys_array_pkg::*; (
  input  logic clk,
  input  logic internal_reset,
  input  logic op0_valid,
  input  logic op1_valid,
  input  logic op0_last,
  input  logic op1_last,
  output logic op0_ready,
  output logic op1_ready,
  input  logic out_full,
  input  logic rslt_ready,
  output logic advance,
  output logic accept,
  output logic out_load,
  output logic out_last,
  output logic err_unaligned,
  output logic core_rst
);

  logic [pipe_depth-1:1]       vld_q;
  logic [pipe_depth-1:1]       last_q;
  logic [reset_pipe_depth-1:0] rst_sr;
  logic                        rst_cause;

  // Whole pipeline moves as one unit
  assign advance = (!out_full || rslt_ready) && !core_rst;
  assign accept  = advance && op0_valid && op1_valid;

  // Join of the two input streams
  assign op0_ready = advance && op1_valid;
  assign op1_ready = advance && op0_valid;

  // Occupancy bit per stage, accept acts as stage 0
  always_ff @(posedge clk) begin
    if (core_rst) begin
      vld_q <= '0;
    end else if (advance) begin
      vld_q <= {vld_q[pipe_depth-2:1], accept};
    end
  end

  // tlast rides beside the occupancy bit
  always_ff @(posedge clk) begin
    if (advance) begin
      last_q <= {last_q[pipe_depth-2:1], op0_last};
    end
  end

  assign out_load = vld_q[pipe_depth-1] && advance;
  assign out_last = last_q[pipe_depth-1];

  // Sticky until the core reset clears it
  always_ff @(posedge clk) begin
    if (core_rst) begin
      err_unaligned <= 1'b0;
    end else if (accept && (op0_last != op1_last)) begin
      err_unaligned <= 1'b1;
    end
  end

  assign rst_cause = internal_reset || err_unaligned;

  // Reset pipeline stretches core_rst past the end of its cause
  always_ff @(posedge clk) begin
    rst_sr   <= {rst_sr[reset_pipe_depth-2:0], rst_cause};
    core_rst <= rst_cause || (|rst_sr);
  end

endmodule

// File: src/linear_array_top.sv
`timescale 1ns/1ns

module linear_array_top import sys_array_pkg::*; (
  input  logic       clk,
  input  logic       internal_reset,
  input  op0_beat_t  op0,
  input  logic       op0_valid,
  output logic       op0_ready,
  input  op1_beat_t  op1,
  input  logic       op1_valid,
  output logic       op1_ready,
  output rslt_beat_t rslt,
  output logic       rslt_valid,
  input  logic       rslt_ready,
  output logic       err_unaligned,
  output logic       core_rst
);

  logic        advance;
  logic        accept;
  logic        out_full;
  logic        out_load;
  logic        out_last;
  data_vec_t   row_data;
  weight_mat_t row_weights;
  psum_row_t   psum_bottom;

  array_control control_i (
    .clk            (clk),
    .internal_reset (internal_reset),
    .op0_valid      (op0_valid),
    .op1_valid      (op1_valid),
    .op0_last       (op0.last),
    .op1_last       (op1.last),
    .op0_ready      (op0_ready),
    .op1_ready      (op1_ready),
    .out_full       (out_full),
    .rslt_ready     (rslt_ready),
    .advance        (advance),
    .accept         (accept),
    .out_load       (out_load),
    .out_last       (out_last),
    .err_unaligned  (err_unaligned),
    .core_rst       (core_rst)
  );

  operand_skew skew_i (
    .clk         (clk),
    .core_rst    (core_rst),
    .advance     (advance),
    .accept      (accept),
    .op0         (op0),
    .op1         (op1),
    .row_data    (row_data),
    .row_weights (row_weights)
  );

  processing_array array_i (
    .clk         (clk),
    .core_rst    (core_rst),
    .advance     (advance),
    .row_data    (row_data),
    .row_weights (row_weights),
    .psum_out    (psum_bottom)
  );

  result_format format_i (
    .clk        (clk),
    .core_rst   (core_rst),
    .out_load   (out_load),
    .rslt_ready (rslt_ready),
    .psum       (psum_bottom),
    .last       (out_last),
    .out_full   (out_full),
    .rslt       (rslt),
    .rslt_valid (rslt_valid)
  );

endmodule

// File: src/operand_skew.sv
`timescale 1ns/1ns

module operand_skew import sys_array_pkg::*; (
  input  logic        clk,
  input  logic        core_rst,
  input  logic        advance,
  input  logic        accept,
  input  op0_beat_t   op0,
  input  op1_beat_t   op1,
  output data_vec_t   row_data,
  output weight_mat_t row_weights
);

  data_vec_t   in_data;
  weight_mat_t in_weights;

  // Bubbles enter the array as zeros
  assign in_data    = accept ? op0.data : '0;
  assign in_weights = accept ? op1.weight : '0;

  for (genvar j = 0; j < data_channels; j++) begin : row_gen
    if (j == 0) begin : direct_gen
      // Top row sees the operands in the acceptance cycle
      assign row_data[0]    = in_data[0];
      assign row_weights[0] = in_weights[0];
    end else begin : delay_gen
      op_t         data_sr [j];
      weight_row_t wgt_sr  [j];

      // Row j is j advance steps late
      always_ff @(posedge clk) begin
        if (core_rst) begin
          for (int k = 0; k < j; k++) begin
            data_sr[k] <= '0;
            wgt_sr[k]  <= '0;
          end
        end else if (advance) begin
          data_sr[0] <= in_data[j];
          wgt_sr[0]  <= in_weights[j];
          for (int k = 1; k < j; k++) begin
            data_sr[k] <= data_sr[k-1];
            wgt_sr[k]  <= wgt_sr[k-1];
          end
        end
      end

      assign row_data[j]    = data_sr[j-1];
      assign row_weights[j] = wgt_sr[j-1];
    end
  end

endmodule

// File: src/processing_array.sv
`timescale 1ns/1ns

module processing_array import sys_array_pkg::*; (
  input  logic        clk,
  input  logic        core_rst,
  input  logic        advance,
  input  data_vec_t   row_data,
  input  weight_mat_t row_weights,
  output psum_row_t   psum_out
);

  // Node j feeds row j, node data_channels is the bottom edge
  psum_t psum_chain [data_channels+1][rslt_channels];

  for (genvar i = 0; i < rslt_channels; i++) begin : edge_gen
    // Nothing flows in from above the top row
    assign psum_chain[0][i] = '0;
    assign psum_out[i]      = psum_chain[data_channels][i];
  end

  for (genvar j = 0; j < data_channels; j++) begin : row_gen
    for (genvar i = 0; i < rslt_channels; i++) begin : col_gen
      // Row data is shared by every column
      processing_element pe_i (
        .clk      (clk),
        .core_rst (core_rst),
        .advance  (advance),
        .data     (row_data[j]),
        .weight   (row_weights[j][i]),
        .psum_in  (psum_chain[j][i]),
        .psum_out (psum_chain[j+1][i])
      );
    end
  end

endmodule

// File: src/processing_element.sv
`timescale 1ns/1ns

module processing_element import sys_array_pkg::*; (
  input  logic  clk,
  input  logic  core_rst,
  input  logic  advance,
  input  op_t   data,
  input  op_t   weight,
  input  psum_t psum_in,
  output psum_t psum_out
);

  logic signed [prod_width-1:0] product;
  psum_t                        product_ext;
  psum_t                        sum;

  // Full precision product, binary point at 2*op_frac_bits
  assign product = $signed(data) * $signed(weight);

  assign product_ext = {{(psum_width-prod_width){product[prod_width-1]}}, product};

  assign sum = psum_in + product_ext;

  always_ff @(posedge clk) begin
    if (core_rst) begin
      psum_out <= '0;
    end else if (advance) begin
      psum_out <= sum;
    end
  end

endmodule

// File: src/result_format.sv
`timescale 1ns/1ns

module result_format import sys_array_pkg::*; (
  input  logic       clk,
  input  logic       core_rst,
  input  logic       out_load,
  input  logic       rslt_ready,
  input  psum_row_t  psum,
  input  logic       last,
  output logic       out_full,
  output rslt_beat_t rslt,
  output logic       rslt_valid
);

  rslt_vec_t scaled;

  // Clamp to the Q4.12 range when the dropped upper bits disagree with the sign
  function automatic rslt_t saturate(input psum_t sum);
    logic [psum_width-rslt_lsb-rslt_width:0] upper;
    upper = sum[psum_width-1:rslt_lsb+rslt_width-1];
    if ((&upper) || !(|upper)) begin
      saturate = sum[rslt_lsb+rslt_width-1:rslt_lsb];
    end else if (sum[psum_width-1]) begin
      saturate = {1'b1, {(rslt_width-1){1'b0}}};
    end else begin
      saturate = {1'b0, {(rslt_width-1){1'b1}}};
    end
  endfunction

  for (genvar i = 0; i < rslt_channels; i++) begin : sat_gen
    assign scaled[i] = saturate(psum[i]);
  end

  always_ff @(posedge clk) begin
    if (core_rst) begin
      out_full <= 1'b0;
    end else if (out_load) begin
      out_full <= 1'b1;
    end else if (rslt_ready) begin
      out_full <= 1'b0;
    end
  end

  // Output payload only changes on a load
  always_ff @(posedge clk) begin
    if (out_load) begin
      rslt <= '{result: scaled, last: last};
    end
  end

  assign rslt_valid = out_full;

endmodule

// File: src/sys_array_pkg.sv
package sys_array_pkg;

  // Array geometry
  localparam int data_channels = 4;
  localparam int rslt_channels = 4;

  // Q4.12 operands and results
  localparam int op_width       = 16;
  localparam int op_frac_bits   = 12;
  localparam int rslt_width     = 16;
  localparam int rslt_frac_bits = 12;

  // Accumulator leaves headroom above the full product
  localparam int prod_width = 2 * op_width;
  localparam int psum_width = 40;
  localparam int rslt_lsb   = 2 * op_frac_bits - rslt_frac_bits;

  // Advance steps from acceptance to the output register
  localparam int pipe_depth       = data_channels + 1;
  localparam int reset_pipe_depth = 3;

  typedef logic signed [op_width-1:0]   op_t;
  typedef logic signed [rslt_width-1:0] rslt_t;
  typedef logic signed [psum_width-1:0] psum_t;

  typedef op_t   [data_channels-1:0] data_vec_t;
  typedef op_t   [rslt_channels-1:0] weight_row_t;
  // Indexed row then column
  typedef weight_row_t [data_channels-1:0] weight_mat_t;
  typedef rslt_t [rslt_channels-1:0] rslt_vec_t;
  typedef psum_t [rslt_channels-1:0] psum_row_t;

  typedef struct packed {
    data_vec_t data;
    logic      last;
  } op0_beat_t;

  typedef struct packed {
    weight_mat_t weight;
    logic        last;
  } op1_beat_t;

  typedef struct packed {
    rslt_vec_t result;
    logic      last;
  } rslt_beat_t;

endpackage

// File: verification/result_checker.sv
`timescale 1ns/1ns

module result_checker import sys_array_pkg::*; (
  input logic       clk,
  input op0_beat_t  op0,
  input logic       op0_valid,
  input logic       op0_ready,
  input op1_beat_t  op1,
  input logic       op1_valid,
  input logic       op1_ready,
  input rslt_beat_t rslt,
  input logic       rslt_valid,
  input logic       rslt_ready,
  input logic       core_rst
);

  int         error_count   = 0;
  int         result_count  = 0;
  int         pending_count = 0;
  int         cycle_count   = 0;
  logic       check_latency = 1'b0;
  rslt_beat_t exp_q [$];
  int         acc_q [$];

  // Column sums of data times weight, scaled back to Q4.12 and clamped
  function automatic rslt_beat_t predict(input op0_beat_t a, input op1_beat_t b);
    logic signed [63:0] acc;
    logic signed [63:0] term;
    rslt_beat_t         r;
    for (int i = 0; i < rslt_channels; i++) begin
      acc = 0;
      for (int j = 0; j < data_channels; j++) begin
        term = $signed(a.data[j]) * $signed(b.weight[j][i]);
        acc  = acc + term;
      end
      acc = acc >>> (2 * op_frac_bits - rslt_frac_bits);
      if (acc > 64'sd32767) begin
        r.result[i] = 16'h7fff;
      end else if (acc < -64'sd32768) begin
        r.result[i] = 16'h8000;
      end else begin
        r.result[i] = acc[15:0];
      end
    end
    r.last = a.last;
    return r;
  endfunction

  task automatic expect_value(input string name, input int expected, input int actual);
    if (actual !== expected) begin
      $display("ERROR %0t ns: %s expected %0d actual %0d", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic compare_result();
    rslt_beat_t expected;
    int         acc_cycle;
    if (exp_q.size() == 0) begin
      $display("Result transfer at %0t ns arrived with no pair pending", $time);
      error_count++;
    end else begin
      expected  = exp_q.pop_front();
      acc_cycle = acc_q.pop_front();
      result_count++;
      if (rslt.result !== expected.result) begin
        $display("ERROR %0t ns: rslt.result expected %h actual %h",
                 $time, expected.result, rslt.result);
        error_count++;
      end
      expect_value("rslt.last", expected.last, rslt.last);
      if (check_latency) begin
        expect_value("result latency", pipe_depth, cycle_count - acc_cycle);
      end
    end
  endtask

  // Sampled mid-cycle, where ports are stable
  always @(negedge clk) begin
    cycle_count++;
    if (core_rst) begin
      exp_q.delete();
      acc_q.delete();
    end else begin
      if (rslt_valid && rslt_ready) begin
        compare_result();
      end
      if (op0_valid && op0_ready && op1_valid && op1_ready) begin
        exp_q.push_back(predict(op0, op1));
        acc_q.push_back(cycle_count);
      end
    end
    pending_count = exp_q.size();
  end

endmodule

// File: verification/tb_top.sv
`timescale 1ns/1ns

module tb_top import sys_array_pkg::*; ();

  localparam int clk_period   = 8;
  localparam int random_beats = 40;
  // Pairs sent over all five tests
  localparam int total_beats  = 87;

  logic       clk;
  logic       internal_reset;
  op0_beat_t  op0;
  logic       op0_valid;
  logic       op0_ready;
  op1_beat_t  op1;
  logic       op1_valid;
  logic       op1_ready;
  rslt_beat_t rslt;
  logic       rslt_valid;
  logic       rslt_ready;
  logic       err_unaligned;
  logic       core_rst;
  logic       ready_random;
  op0_beat_t  rand_op0 [random_beats];
  op1_beat_t  rand_op1 [random_beats];
  op0_beat_t  bad_op0;
  op1_beat_t  bad_op1;
  int         pass_count;
  int         fail_count;
  int         errors_at_start;
  int         results_before;

  linear_array_top dut_i (.*);

  result_checker checker_i (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Watchdog
  initial begin
    #(total_beats * 20 * clk_period + 2000);
    $display("Timeout: the tests did not finish within the time limit");
    $display("Test failed");
    $finish;
  end

  // Random back-pressure on the result stream
  always @(posedge clk) begin
    #1;
    if (ready_random) begin
      rslt_ready = ($urandom_range(0, 1) == 1);
    end
  end

  // About -3.0 to +3.0, so some sums saturate
  function automatic op_t rand_op();
    int v;
    v = $urandom_range(0, 24575) - 12288;
    return v[15:0];
  endfunction

  // Starts and ends 1 ns past a rising edge
  task automatic send_pair(input op0_beat_t a, input op1_beat_t b);
    op0       = a;
    op1       = b;
    op0_valid = 1'b1;
    op1_valid = 1'b1;
    @(negedge clk);
    while (!(op0_ready && op1_ready)) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic stop_input();
    op0_valid = 1'b0;
    op1_valid = 1'b0;
  endtask

  task automatic wait_drain();
    @(posedge clk);
    #2;
    while (checker_i.pending_count != 0 || rslt_valid) begin
      @(posedge clk);
      #2;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = checker_i.error_count - errors_at_start;
    if (errs == 0) begin
      $display("%s: ok", name);
      pass_count++;
    end else begin
      $display("%s: %0d errors", name, errs);
      fail_count++;
    end
    errors_at_start = checker_i.error_count;
  endtask

  initial begin
    void'($urandom(32'h8dea_f8ac));
    internal_reset  = 1'b1;
    op0             = '0;
    op1             = '0;
    op0_valid       = 1'b0;
    op1_valid       = 1'b0;
    rslt_ready      = 1'b1;
    ready_random    = 1'b0;
    pass_count      = 0;
    fail_count      = 0;
    errors_at_start = 0;
    for (int k = 0; k < random_beats; k++) begin
      for (int j = 0; j < data_channels; j++) begin
        rand_op0[k].data[j] = rand_op();
        for (int i = 0; i < rslt_channels; i++) begin
          rand_op1[k].weight[j][i] = rand_op();
        end
      end
      rand_op0[k].last = (k % 8 == 7);
      rand_op1[k].last = (k % 8 == 7);
    end

    // Identity weights with both inputs valid through reset
    op0.data = {16'sh2000, -16'sh0800, 16'sh0400, 16'sh1000};
    for (int j = 0; j < data_channels; j++) begin
      for (int i = 0; i < rslt_channels; i++) begin
        op1.weight[j][i] = (i == j) ? 16'sd4096 : 16'sd0;
      end
    end
    op0_valid = 1'b1;
    op1_valid = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    internal_reset = 1'b0;
    @(negedge clk);
    checker_i.expect_value("rslt_valid", 0, rslt_valid);
    checker_i.expect_value("err_unaligned", 0, err_unaligned);
    checker_i.expect_value("op0_ready", 0, op0_ready);
    checker_i.expect_value("op1_ready", 0, op1_ready);
    checker_i.expect_value("core_rst", 1, core_rst);
    while (core_rst) begin
      @(negedge clk);
    end
    checker_i.expect_value("op0_ready", 1, op0_ready);
    checker_i.expect_value("op1_ready", 1, op1_ready);
    @(posedge clk);
    #1;
    stop_input();
    wait_drain();
    finish_test("test 1 reset and join");

    op0.data = {16'sh7fff, -16'sh3000, 16'sh0123, -16'sh0001};
    send_pair(op0, op1);
    // Full-scale columns push the sums past both ends of the range
    for (int j = 0; j < data_channels; j++) begin
      for (int i = 0; i < rslt_channels; i++) begin
        op1.weight[j][i] = (i < 2) ? 16'sh7fff : 16'sh8000;
      end
    end
    op0.data = {4{16'sh7fff}};
    send_pair(op0, op1);
    stop_input();
    wait_drain();
    finish_test("test 2 identity and saturation");

    results_before          = checker_i.result_count;
    checker_i.check_latency = 1'b1;
    for (int k = 0; k < random_beats; k++) begin
      send_pair(rand_op0[k], rand_op1[k]);
    end
    stop_input();
    wait_drain();
    checker_i.check_latency = 1'b0;
    checker_i.expect_value("result_count", results_before + random_beats,
                           checker_i.result_count);
    finish_test("test 3 back-to-back random");

    results_before = checker_i.result_count;
    ready_random   = 1'b1;
    for (int k = 0; k < random_beats; k++) begin
      send_pair(rand_op0[k], rand_op1[k]);
    end
    stop_input();
    wait_drain();
    ready_random = 1'b0;
    rslt_ready   = 1'b1;
    checker_i.expect_value("result_count", results_before + random_beats,
                           checker_i.result_count);
    finish_test("test 4 random back-pressure");

    // Two good pairs in flight, then tlast disagrees
    results_before = checker_i.result_count;
    send_pair(rand_op0[1], rand_op1[1]);
    send_pair(rand_op0[2], rand_op1[2]);
    bad_op0      = rand_op0[3];
    bad_op1      = rand_op1[3];
    bad_op0.last = 1'b1;
    bad_op1.last = 1'b0;
    send_pair(bad_op0, bad_op1);
    stop_input();
    @(negedge clk);
    checker_i.expect_value("err_unaligned", 1, err_unaligned);
    checker_i.expect_value("core_rst", 0, core_rst);
    @(negedge clk);
    checker_i.expect_value("core_rst", 1, core_rst);
    while (core_rst) begin
      @(negedge clk);
    end
    checker_i.expect_value("err_unaligned", 0, err_unaligned);
    checker_i.expect_value("rslt_valid", 0, rslt_valid);
    checker_i.expect_value("result_count", results_before, checker_i.result_count);
    @(posedge clk);
    #1;
    send_pair(rand_op0[4], rand_op1[4]);
    stop_input();
    wait_drain();
    checker_i.expect_value("result_count", results_before + 1, checker_i.result_count);
    finish_test("test 5 unaligned tlast recovery");

    $display("Summary: %0d tests ok, %0d tests with errors", pass_count, fail_count);
    if (fail_count == 0 && checker_i.error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
src/sys_array_pkg.sv
src/processing_element.sv
src/processing_array.sv
src/operand_skew.sv
src/array_control.sv
src/result_format.sv
src/linear_array_top.sv
verification/result_checker.sv
verification/tb_top.sv
